// ==== all.f ====
+incdir+common
common/md_pkg.sv
source/clock_enables.sv
mbus/mbus_ctrl.sv
mbus/cart_mapper.sv
source/work_ram.sv
source/z80_ctrl_regs.sv
source/md_bus_top.sv
verification/md_bus_sva.sv
verification/md_bus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module md_bus_tb -f all.f -o md_bus_sim

./obj_dir/md_bus_sim 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== verification/md_bus_tb.sv ====
module md_bus_tb;

	// One bus cycle of the table with its expected results
	typedef struct packed {
		logic rnw;
		logic [23:0] addr;
		md_pkg::word_t wdata;
		logic [1:0] strobe_n;
		md_pkg::turbo_t turbo;
		logic busak_n;
		md_pkg::word_t exp_data;
		logic [3:0] lat;
		logic [1:0] exp_ctrl;
	} row_t;

	logic MCLK;
	logic reset;
	md_pkg::turbo_t turbo;
	logic as_n;
	md_pkg::mbus_req_t cpu_req;
	md_pkg::rom_addr_t rom_size;
	md_pkg::word_t rom_data;
	logic rom_ack;
	logic z80_busak_n;
	md_pkg::word_t rdata;
	logic dtack_n;
	md_pkg::rom_addr_t rom_addr;
	logic rom_req;
	logic z80_busreq_n;
	logic z80_reset_n;
	logic m68k_cen_p;
	logic m68k_cen_n;
	logic z80_cen;

	row_t rows [$];
	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 200;

	md_bus_top UUT (
		.MCLK(MCLK),
		.reset(reset),
		.turbo(turbo),
		.as_n(as_n),
		.cpu_req(cpu_req),
		.rom_size(rom_size),
		.rom_data(rom_data),
		.rom_ack(rom_ack),
		.z80_busak_n(z80_busak_n),
		.rdata(rdata),
		.dtack_n(dtack_n),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n),
		.m68k_cen_p(m68k_cen_p),
		.m68k_cen_n(m68k_cen_n),
		.z80_cen(z80_cen)
	);

	initial begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			stop_with_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Cartridge contents, folded so every ROM address bit shows in the data
	function automatic md_pkg::word_t rom_pattern(input md_pkg::rom_addr_t a);
		return a[15:0] ^ {7'd0, a[24:16]} ^ 16'h5a5a;
	endfunction

	// Cycles past this limit count as a hang
	always @(posedge MCLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_with_failure("Timeout: the bus or the enables stopped responding");
		end
	end

	// --------------------------------------------------
	// Cartridge ROM responder
	// --------------------------------------------------
	initial begin : rom_responder
		logic [31:0] lfsr;
		int wait_cycles;
		lfsr = 32'hfcd;
		rom_ack = 1'b0;
		rom_data = '0;
		forever begin
			@(negedge MCLK);
			if (!reset && (rom_req !== rom_ack)) begin
				wait_cycles = 0;
				repeat (3) begin
					wait_cycles = (wait_cycles << 1) | int'(lfsr[0]);
					lfsr = galois_step(lfsr);
				end
				repeat (wait_cycles) @(negedge MCLK);
				rom_data = rom_pattern(rom_addr);
				rom_ack = rom_req;
			end
		end
	end

	task automatic add_row(input logic rnw, input logic [23:0] addr, input md_pkg::word_t wdata,
		input logic [1:0] strobe_n, input md_pkg::turbo_t turbo_sel, input logic busak_n,
		input md_pkg::word_t exp_data, input int lat, input logic [1:0] exp_ctrl);
		row_t r;
		r.rnw = rnw;
		r.addr = addr;
		r.wdata = wdata;
		r.strobe_n = strobe_n;
		r.turbo = turbo_sel;
		r.busak_n = busak_n;
		r.exp_data = exp_data;
		r.lat = 4'(lat);
		r.exp_ctrl = exp_ctrl;
		rows.push_back(r);
	endtask

	// Columns: rnw, byte address, wdata, {uds_n, lds_n}, turbo, z80_busak_n,
	// read data, dtack latency (0 for ROM), {z80_busreq_n, z80_reset_n}
	task automatic load_table();
		// Sub-CPU control registers
		add_row(1'b1, 24'hA11100, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0100, 2, 2'b10);
		add_row(1'b1, 24'hA11200, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b0, 24'hA11100, 16'h0100, 2'b01, 2'd0, 1'b1, 16'h0000, 2, 2'b00);
		add_row(1'b0, 24'hA11200, 16'h0100, 2'b01, 2'd0, 1'b1, 16'h0000, 2, 2'b01);
		add_row(1'b1, 24'hA11200, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0100, 2, 2'b01);
		add_row(1'b1, 24'hA11100, 16'h0000, 2'b00, 2'd0, 1'b0, 16'h0000, 2, 2'b01);
		add_row(1'b0, 24'hA11101, 16'h0000, 2'b10, 2'd0, 1'b0, 16'h0000, 2, 2'b01);
		add_row(1'b0, 24'hA11201, 16'h0000, 2'b10, 2'd0, 1'b0, 16'h0000, 2, 2'b01);
		add_row(1'b0, 24'hA11100, 16'h0000, 2'b01, 2'd0, 1'b1, 16'h0000, 2, 2'b11);
		add_row(1'b0, 24'hA11200, 16'h0000, 2'b01, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		// Work RAM, byte lanes and mirror
		add_row(1'b0, 24'hE00010, 16'h1234, 2'b00, 2'd1, 1'b1, 16'h0000, 3, 2'b10);
		add_row(1'b1, 24'hE00010, 16'h0000, 2'b00, 2'd1, 1'b1, 16'h1234, 3, 2'b10);
		add_row(1'b0, 24'hE01000, 16'h1111, 2'b00, 2'd1, 1'b1, 16'h0000, 3, 2'b10);
		add_row(1'b0, 24'hE01000, 16'h2200, 2'b01, 2'd1, 1'b1, 16'h0000, 3, 2'b10);
		add_row(1'b0, 24'hE01000, 16'h0033, 2'b10, 2'd1, 1'b1, 16'h0000, 3, 2'b10);
		add_row(1'b1, 24'hE01000, 16'h0000, 2'b00, 2'd1, 1'b1, 16'h2233, 3, 2'b10);
		add_row(1'b1, 24'hFF1000, 16'h0000, 2'b00, 2'd1, 1'b1, 16'h2233, 3, 2'b10);
		add_row(1'b0, 24'hFFFFFE, 16'hABCD, 2'b00, 2'd2, 1'b1, 16'h0000, 3, 2'b10);
		add_row(1'b1, 24'hFFFFFE, 16'h0000, 2'b00, 2'd2, 1'b1, 16'hABCD, 3, 2'b10);
		add_row(1'b1, 24'hEFFFFE, 16'h0000, 2'b00, 2'd2, 1'b1, 16'hABCD, 3, 2'b10);
		// Unbanked ROM and the space above rom_size
		add_row(1'b1, 24'h000000, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h000000), 0, 2'b10);
		add_row(1'b1, 24'h000246, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h000123), 0, 2'b10);
		add_row(1'b1, 24'h123456, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h091A2B), 0, 2'b10);
		add_row(1'b1, 24'h1FFFFE, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h0FFFFF), 0, 2'b10);
		add_row(1'b1, 24'h200000, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b1, 24'h9FFFFE, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		// Mapper, bank 9 into slot 1 and back
		add_row(1'b0, 24'hA130F3, 16'h0009, 2'b10, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b1, 24'h08ACE0, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h245670), 0, 2'b10);
		add_row(1'b1, 24'h000246, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h000123), 0, 2'b10);
		add_row(1'b1, 24'hA130F3, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b0, 24'hA130F1, 16'h0000, 2'b10, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b1, 24'h08ACE0, 16'h0000, 2'b00, 2'd0, 1'b1, rom_pattern(24'h045670), 0, 2'b10);
		// Unmapped
		add_row(1'b1, 24'hC00000, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
		add_row(1'b1, 24'hA10000, 16'h0000, 2'b00, 2'd0, 1'b1, 16'h0000, 2, 2'b10);
	endtask

	// --------------------------------------------------
	// Bus cycle and enable measurements
	// --------------------------------------------------
	task automatic run_row(input row_t r);
		int cycles;
		md_pkg::mbus_req_t req;
		req.addr = r.addr[23:1];
		req.wdata = r.wdata;
		req.rnw = r.rnw;
		req.uds_n = r.strobe_n[1];
		req.lds_n = r.strobe_n[0];
		cycles = 0;
		@(negedge MCLK);
		turbo = r.turbo;
		z80_busak_n = r.busak_n;
		cpu_req = req;
		as_n = 1'b0;
		while (dtack_n) begin
			@(negedge MCLK);
			cycles++;
		end
		// First edge accepts, then lat edges until dtack_n
		if (r.lat != 4'd0) begin
			compare_value("dtack_n latency", 32'(cycles - 1), 32'(r.lat));
		end
		if (r.rnw) begin
			compare_value("rdata", 32'(rdata), 32'(r.exp_data));
		end
		as_n = 1'b1;
		while (!dtack_n) begin
			@(negedge MCLK);
		end
		compare_value("z80_busreq_n", 32'(z80_busreq_n), 32'(r.exp_ctrl[1]));
		compare_value("z80_reset_n", 32'(z80_reset_n), 32'(r.exp_ctrl[0]));
		compare_value("rom_req", 32'(rom_req), 32'(rom_ack));
	endtask

	task automatic measure_cpu_enables(input md_pkg::turbo_t t, input int period, input int mid);
		int gap;
		int neg_pulses;
		int neg_at;
		@(negedge MCLK);
		turbo = t;
		// New setting loads at the next wrap
		do begin
			@(negedge MCLK);
		end while (!m68k_cen_p);
		gap = 0;
		neg_pulses = 0;
		neg_at = 0;
		do begin
			@(negedge MCLK);
			gap++;
			if (m68k_cen_n) begin
				neg_pulses++;
				neg_at = gap;
			end
		end while (!m68k_cen_p);
		compare_value("m68k_cen_p period", 32'(gap), 32'(period));
		compare_value("m68k_cen_n pulses", 32'(neg_pulses), 32'd1);
		compare_value("m68k_cen_n position", 32'(neg_at), 32'(mid + 1));
	endtask

	task automatic measure_z80_enable();
		int gap;
		do begin
			@(negedge MCLK);
		end while (!z80_cen);
		gap = 0;
		do begin
			@(negedge MCLK);
			gap++;
		end while (!z80_cen);
		compare_value("z80_cen period", 32'(gap), 32'd15);
	endtask

	initial begin : main
		reset = 1'b1;
		turbo = 2'd0;
		as_n = 1'b1;
		cpu_req = '0;
		rom_size = 24'h100000;
		z80_busak_n = 1'b1;
		load_table();
		cycle_limit = 60 * rows.size() + 200;
		repeat (2) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;

		compare_value("dtack_n", 32'(dtack_n), 32'd1);
		compare_value("z80_busreq_n", 32'(z80_busreq_n), 32'd1);
		compare_value("z80_reset_n", 32'(z80_reset_n), 32'd0);
		compare_value("rom_req", 32'(rom_req), 32'(rom_ack));
		compare_value("m68k_cen_p", 32'(m68k_cen_p), 32'd0);
		compare_value("m68k_cen_n", 32'(m68k_cen_n), 32'd0);
		compare_value("z80_cen", 32'(z80_cen), 32'd0);

		for (int i = 0; i < rows.size(); i++) begin
			run_row(rows[i]);
		end

		measure_cpu_enables(2'd0, 7, 3);
		measure_cpu_enables(2'd1, 4, 1);
		measure_cpu_enables(2'd2, 2, 0);
		measure_z80_enable();

		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stop_with_failure("One or more checks failed");
		end
	end

endmodule

// ==== verification/md_bus_sva.sv ====
module md_bus_sva (
	input logic MCLK,
	input logic reset,
	input logic as_n,
	input logic dtack_n,
	input logic rom_req,
	input md_pkg::mbus_state_t state,
	input logic ram_we_u,
	input logic ram_we_l,
	input logic map_we,
	input logic ctrl_we
);

	// dtack_n only falls inside a cycle opened by as_n
	dtack_needs_as: assert property (@(posedge MCLK) disable iff (reset)
		$fell(dtack_n) |-> !$past(as_n))
		else $error("dtack_n fell while as_n was high");

	// ROM handshake starts from select only
	rom_req_in_select: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> ($past(state) == md_pkg::select))
		else $error("rom_req toggled outside select");

	// Cycle ends at most 2 cycles after as_n rises
	dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		(as_n && $past(as_n) && $past(as_n, 2)) |-> dtack_n)
		else $error("dtack_n still low 2 cycles after as_n rose");

	one_write_target: assert property (@(posedge MCLK) disable iff (reset)
		$onehot0({ram_we_u | ram_we_l, map_we, ctrl_we}))
		else $error("more than one write target strobed");

endmodule

bind mbus_ctrl md_bus_sva u_md_bus_sva (
	.MCLK(MCLK),
	.reset(reset),
	.as_n(as_n),
	.dtack_n(dtack_n),
	.rom_req(rom_req),
	.state(state),
	.ram_we_u(ram_we_u),
	.ram_we_l(ram_we_l),
	.map_we(map_we),
	.ctrl_we(ctrl_we)
);

// ==== source/md_bus_top.sv ====
`include "md_defs.svh"

module md_bus_top (
	input logic MCLK,
	input logic reset,
	input md_pkg::turbo_t turbo,
	input logic as_n,
	input md_pkg::mbus_req_t cpu_req,
	input md_pkg::rom_addr_t rom_size,
	input md_pkg::word_t rom_data,
	input logic rom_ack,
	input logic z80_busak_n,
	output md_pkg::word_t rdata,
	output logic dtack_n,
	output md_pkg::rom_addr_t rom_addr,
	output logic rom_req,
	output logic z80_busreq_n,
	output logic z80_reset_n,
	output logic m68k_cen_p,
	output logic m68k_cen_n,
	output logic z80_cen
);

	md_pkg::mbus_req_t mbus_req;
	md_pkg::word_t ram_q;
	md_pkg::word_t ctrl_q;
	logic ram_we_u;
	logic ram_we_l;
	logic map_we;
	logic ctrl_we;

	// --------------------------------------------------
	// Clocking
	// --------------------------------------------------
	clock_enables u_clock_enables (
		.MCLK(MCLK),
		.reset(reset),
		.turbo(turbo),
		.m68k_cen_p(m68k_cen_p),
		.m68k_cen_n(m68k_cen_n),
		.z80_cen(z80_cen)
	);

	// --------------------------------------------------
	// Bus controller and its targets
	// --------------------------------------------------
	mbus_ctrl u_mbus_ctrl (
		.MCLK(MCLK),
		.reset(reset),
		.as_n(as_n),
		.cpu_req(cpu_req),
		.rom_size(rom_size),
		.rom_data(rom_data),
		.rom_ack(rom_ack),
		.ram_q(ram_q),
		.ctrl_q(ctrl_q),
		.mbus_req(mbus_req),
		.rdata(rdata),
		.dtack_n(dtack_n),
		.rom_req(rom_req),
		.ram_we_u(ram_we_u),
		.ram_we_l(ram_we_l),
		.map_we(map_we),
		.ctrl_we(ctrl_we)
	);

	cart_mapper u_cart_mapper (
		.MCLK(MCLK),
		.reset(reset),
		.mbus_req(mbus_req),
		.map_we(map_we),
		.rom_addr(rom_addr)
	);

	// 64 KB mirrored over E00000-FFFFFF
	work_ram u_work_ram (
		.MCLK(MCLK),
		.addr(mbus_req.addr[`MD_RAM_AW:1]),
		.wdata(mbus_req.wdata),
		.we_u(ram_we_u),
		.we_l(ram_we_l),
		.q(ram_q)
	);

	z80_ctrl_regs u_z80_ctrl_regs (
		.MCLK(MCLK),
		.reset(reset),
		.mbus_req(mbus_req),
		.ctrl_we(ctrl_we),
		.z80_busak_n(z80_busak_n),
		.ctrl_q(ctrl_q),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

endmodule

// ==== source/z80_ctrl_regs.sv ====
`include "md_defs.svh"

module z80_ctrl_regs (
	input logic MCLK,
	input logic reset,
	input md_pkg::mbus_req_t mbus_req,
	input logic ctrl_we,
	input logic z80_busak_n,
	output md_pkg::word_t ctrl_q,
	output logic z80_busreq_n,
	output logic z80_reset_n
);

	logic is_busreq;
	logic is_reset;

	// A11100 bus request, A11200 reset
	assign is_busreq = (mbus_req.addr[11:8] == `MD_CTRL_BUSREQ);
	assign is_reset = (mbus_req.addr[11:8] == `MD_CTRL_RESET);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_we) begin
			if (is_busreq) begin
				z80_busreq_n <= ~mbus_req.wdata[8];
			end
			if (is_reset) begin
				z80_reset_n <= mbus_req.wdata[8];
			end
		end
	end

	// Status only on D8
	always_comb begin
		ctrl_q = '0;
		if (is_busreq) begin
			ctrl_q[8] = z80_busak_n;
		end else if (is_reset) begin
			ctrl_q[8] = z80_reset_n;
		end
	end

endmodule

// ==== source/work_ram.sv ====
`include "md_defs.svh"

module work_ram (
	input logic MCLK,
	input logic [`MD_RAM_AW-1:0] addr,
	input md_pkg::word_t wdata,
	input logic we_u,
	input logic we_l,
	output md_pkg::word_t q
);

	// One array per byte lane for byte writes
	md_pkg::byte_t mem_u [2**`MD_RAM_AW];
	md_pkg::byte_t mem_l [2**`MD_RAM_AW];

	always_ff @(posedge MCLK) begin
		if (we_u) begin
			mem_u[addr] <= wdata[15:8];
		end
		if (we_l) begin
			mem_l[addr] <= wdata[7:0];
		end
		// Registered read, old data on a same-cycle write
		q <= {mem_u[addr], mem_l[addr]};
	end

endmodule

// ==== mbus/cart_mapper.sv ====
`include "md_defs.svh"

module cart_mapper (
	input logic MCLK,
	input logic reset,
	input md_pkg::mbus_req_t mbus_req,
	input logic map_we,
	output md_pkg::rom_addr_t rom_addr
);

	md_pkg::bank_t bank_regs [`MD_BANK_COUNT];
	logic banking;
	logic [2:0] reg_idx;

	// Register index from A3..A1
	assign reg_idx = mbus_req.addr[3:1];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			banking <= 1'b0;
			// Identity mapping of the first 4 MB
			for (int i = 0; i < `MD_BANK_COUNT; i++) begin
				bank_regs[i] <= md_pkg::bank_t'(i);
			end
		end else if (map_we) begin
			if (reg_idx != 3'd0) begin
				bank_regs[reg_idx] <= mbus_req.wdata[`MD_BANK_W-1:0];
				banking <= 1'b1;
			end else if (!mbus_req.wdata[0]) begin
				banking <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// ROM address translation
	// --------------------------------------------------
	// Each bank covers a 512 KB window selected by A21..A19
	always_comb begin
		if (banking) begin
			rom_addr = {1'b0, bank_regs[mbus_req.addr[21:19]], mbus_req.addr[18:1]};
		end else begin
			rom_addr = {1'b0, mbus_req.addr};
		end
	end

endmodule

// ==== mbus/mbus_ctrl.sv ====
`include "md_defs.svh"

module mbus_ctrl (
	input logic MCLK,
	input logic reset,
	input logic as_n,
	input md_pkg::mbus_req_t cpu_req,
	input md_pkg::rom_addr_t rom_size,
	input md_pkg::word_t rom_data,
	input logic rom_ack,
	input md_pkg::word_t ram_q,
	input md_pkg::word_t ctrl_q,
	output md_pkg::mbus_req_t mbus_req,
	output md_pkg::word_t rdata,
	output logic dtack_n,
	output logic rom_req,
	output logic ram_we_u,
	output logic ram_we_l,
	output logic map_we,
	output logic ctrl_we
);

	md_pkg::mbus_state_t state;

	logic accept;
	logic hit_rom;
	logic hit_ctrl;
	logic hit_map;
	logic hit_ram;
	logic wr_cycle;
	logic rom_done;

	// --------------------------------------------------
	// Address decode, in priority order
	// --------------------------------------------------
	assign hit_rom = (mbus_req.addr[23:20] < `MD_ROM_TOP) &&
		({1'b0, mbus_req.addr} < rom_size);
	assign hit_ctrl = !hit_rom && (mbus_req.addr[23:12] == `MD_CTRL_PAGE) &&
		(mbus_req.addr[7:1] == 7'd0);
	assign hit_map = !hit_rom && !hit_ctrl && (mbus_req.addr[23:8] == `MD_MAP_PAGE);
	assign hit_ram = !hit_rom && !hit_ctrl && !hit_map && (&mbus_req.addr[23:21]);

	assign accept = (state == md_pkg::idle) && !as_n && dtack_n;
	assign rom_done = (state == md_pkg::rom_read) && (rom_req == rom_ack);

	// Write strobes last exactly the one select cycle
	assign wr_cycle = (state == md_pkg::select) && !mbus_req.rnw;
	assign ram_we_u = wr_cycle && hit_ram && !mbus_req.uds_n;
	assign ram_we_l = wr_cycle && hit_ram && !mbus_req.lds_n;
	assign map_we = wr_cycle && hit_map;
	assign ctrl_we = wr_cycle && hit_ctrl && !mbus_req.uds_n;

	// --------------------------------------------------
	// Sequencer
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= md_pkg::idle;
			dtack_n <= 1'b1;
			rom_req <= rom_ack;
		end else begin
			case (state)
				md_pkg::idle: begin
					dtack_n <= 1'b1;
					if (accept) begin
						state <= md_pkg::select;
					end
				end

				md_pkg::select: begin
					if (hit_rom && mbus_req.rnw) begin
						// Toggle handshake to the cartridge port
						rom_req <= ~rom_ack;
						state <= md_pkg::rom_read;
					end else if (hit_ram) begin
						state <= md_pkg::ram_read;
					end else begin
						// Mapper, control and unmapped skip the wait state
						state <= md_pkg::finish;
					end
				end

				md_pkg::ram_read: begin
					state <= md_pkg::finish;
				end

				md_pkg::rom_read: begin
					if (rom_done) begin
						state <= md_pkg::finish;
					end
				end

				md_pkg::finish: begin
					dtack_n <= 1'b0;
					// Master ends the cycle by raising AS
					if (as_n) begin
						state <= md_pkg::idle;
					end
				end

				default: begin
					state <= md_pkg::idle;
				end
			endcase
		end
	end

	// Request latch and read data
	always_ff @(posedge MCLK) begin
		if (accept) begin
			mbus_req <= cpu_req;
		end

		if (state == md_pkg::select) begin
			rdata <= hit_ctrl ? ctrl_q : '0;
		end else if (state == md_pkg::ram_read) begin
			rdata <= ram_q;
		end else if (rom_done) begin
			rdata <= rom_data;
		end
	end

endmodule

// ==== source/clock_enables.sv ====
`include "md_defs.svh"

module clock_enables (
	input logic MCLK,
	input logic reset,
	input md_pkg::turbo_t turbo,
	output logic m68k_cen_p,
	output logic m68k_cen_n,
	output logic z80_cen
);

	logic [3:0] m68k_cnt;
	logic [3:0] m68k_last;
	logic [3:0] m68k_mid;
	logic [3:0] z80_cnt;

	// Last count of the 68000 period
	function automatic logic [3:0] last_count(input md_pkg::turbo_t t);
		case (t)
			2'd1: last_count = 4'(`MD_CEN_PERIOD_T1 - 1);
			2'd2: last_count = 4'(`MD_CEN_PERIOD_T2 - 1);
			default: last_count = 4'(`MD_CEN_PERIOD_NORMAL - 1);
		endcase
	endfunction

	function automatic logic [3:0] mid_count(input md_pkg::turbo_t t);
		case (t)
			2'd1: mid_count = 4'(`MD_CEN_MID_T1);
			2'd2: mid_count = 4'(`MD_CEN_MID_T2);
			default: mid_count = 4'(`MD_CEN_MID_NORMAL);
		endcase
	endfunction

	always_ff @(posedge MCLK) begin
		if (reset) begin
			m68k_cnt <= '0;
			z80_cnt <= '0;
			m68k_last <= last_count(turbo);
			m68k_mid <= mid_count(turbo);
			m68k_cen_p <= 1'b0;
			m68k_cen_n <= 1'b0;
			z80_cen <= 1'b0;
		end else begin
			// Turbo is only sampled at the wrap so no phase gets cut short
			m68k_cen_p <= 1'b0;
			if (m68k_cnt == m68k_last) begin
				m68k_cnt <= '0;
				m68k_cen_p <= 1'b1;
				m68k_last <= last_count(turbo);
				m68k_mid <= mid_count(turbo);
			end else begin
				m68k_cnt <= m68k_cnt + 4'd1;
			end
			m68k_cen_n <= (m68k_cnt == m68k_mid);

			// Z80 runs from a fixed divider
			z80_cen <= 1'b0;
			if (z80_cnt == 4'(`MD_ZCEN_PERIOD - 1)) begin
				z80_cnt <= '0;
				z80_cen <= 1'b1;
			end else begin
				z80_cnt <= z80_cnt + 4'd1;
			end
		end
	end

endmodule

// ==== common/md_pkg.sv ====
`include "md_defs.svh"

package md_pkg;

	// 68000 word address, A0 is carried by the strobes
	typedef logic [23:1] m68k_addr_t;

	// Cartridge ROM word address
	typedef logic [24:1] rom_addr_t;

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [`MD_BANK_W-1:0] bank_t;

	// 0 normal, 1 fast, 2 fastest
	typedef logic [1:0] turbo_t;

	// --------------------------------------------------
	// Latched bus request
	// --------------------------------------------------
	typedef struct packed {
		m68k_addr_t addr;
		word_t wdata;
		logic rnw;
		logic uds_n;
		logic lds_n;
	} mbus_req_t;

	// Main bus sequencer
	typedef enum logic [2:0] {
		idle,
		select,
		ram_read,
		rom_read,
		finish
	} mbus_state_t;

endpackage

// ==== common/md_defs.svh ====
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Work RAM word address width
`define MD_RAM_AW 15

// Cartridge mapper bank registers
`define MD_BANK_COUNT 8
`define MD_BANK_W 5

// Clock enable periods in MCLK cycles
`define MD_ZCEN_PERIOD 15
`define MD_CEN_PERIOD_NORMAL 7
`define MD_CEN_PERIOD_T1 4
`define MD_CEN_PERIOD_T2 2

// Negative phase position inside the 68000 period
`define MD_CEN_MID_NORMAL 3
`define MD_CEN_MID_T1 1
`define MD_CEN_MID_T2 0

// Address windows on the upper address bits
`define MD_ROM_TOP 4'hA
`define MD_CTRL_PAGE 12'hA11
`define MD_CTRL_BUSREQ 4'h1
`define MD_CTRL_RESET 4'h2
`define MD_MAP_PAGE 16'hA130

`endif
